// ==== Makefile ====
# Verilator flow for the Sv32 page-table walker

VERILATOR ?= verilator
TOP       ?= ptw_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: PASS"; \
	else \
		echo "sim: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+.
ptw_pkg.sv
ptw_miss_capture.sv
ptw_mem_port.sv
ptw_pte_check.sv
ptw_walk_fsm.sv
ptw_tlb_update.sv
ptw_top.sv
ptw_tb_assertions.sv
ptw_tb.sv

// ==== ptw_defines.svh ====
// ------------------------------
// Sv32 widths and PTE bit positions
// only one translation stage with two levels is covered
// ------------------------------
`ifndef PTW_DEFINES_SVH
`define PTW_DEFINES_SVH

// address and page widths
`define PTW_VLEN 32
`define PTW_PLEN 34
`define PTW_PPNW 22
`define PTW_VPNW 10
`define PTW_OFFW 12
`define PTW_ASIDW 9

// permission and status bits of a PTE
`define PTW_PTE_V 0
`define PTW_PTE_R 1
`define PTW_PTE_W 2
`define PTW_PTE_X 3
`define PTW_PTE_U 4
`define PTW_PTE_G 5
`define PTW_PTE_A 6
`define PTW_PTE_D 7
// ppn sits above the two rsw bits
`define PTW_PTE_PPN_LSB 10

`endif

// ==== ptw_mem_port.sv ====
// ------------------------------
// single outstanding PTE read
// request is held until grant; rvalid and rdata are registered
// ------------------------------
`timescale 1ns/1ps

module ptw_mem_port
  import ptw_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_i,
  input  paddr_t fetch_addr_i,
  input  logic   mem_gnt_i,
  input  logic   mem_rvalid_i,
  input  pte_t   mem_rdata_i,
  output logic   mem_req_o,
  output paddr_t mem_addr_o,
  output logic   pte_valid_o,
  output pte_t   pte_o
);

  // ------------------------------
  // request side
  // ------------------------------
  // req rises the cycle after fetch, drops after the granted cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_req_o <= 1'b0;
    end else if (fetch_i) begin
      mem_req_o <= 1'b1;
    end else if (mem_gnt_i) begin
      mem_req_o <= 1'b0;
    end
  end

  // address stays put while waiting for the grant
  always_ff @(posedge clk_i) begin
    if (fetch_i) begin
      mem_addr_o <= fetch_addr_i;
    end
  end

  // ------------------------------
  // response side
  // ------------------------------
  // input registers, pte_valid lags rvalid by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pte_valid_o <= 1'b0;
    end else begin
      pte_valid_o <= mem_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pte_o <= mem_rdata_i;
  end

endmodule

// ==== ptw_miss_capture.sv ====
// ------------------------------
// miss intake, one walk at a time
// context is latched at accept and held until the next accept
// ------------------------------
`timescale 1ns/1ps

module ptw_miss_capture
  import ptw_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   miss_valid_i,
  input  vaddr_t miss_vaddr_i,
  input  asid_t  miss_asid_i,
  input  logic   miss_is_instr_i,
  input  logic   miss_is_store_i,
  input  logic   mxr_i,
  input  ppn_t   satp_ppn_i,
  input  logic   busy_i,
  output logic   miss_ready_o,
  output logic   accept_o,
  output vaddr_t ctx_vaddr_o,
  output asid_t  ctx_asid_o,
  output logic   ctx_is_instr_o,
  output logic   ctx_is_store_o,
  output logic   ctx_mxr_o,
  output ppn_t   ctx_root_ppn_o
);

  // ready only while no walk is running
  assign miss_ready_o = ~busy_i;
  assign accept_o     = miss_valid_i & miss_ready_o;

  // context registers, payload only
  // satp is sampled here too so a csr write mid-walk has no effect
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      ctx_vaddr_o    <= miss_vaddr_i;
      ctx_asid_o     <= miss_asid_i;
      ctx_is_instr_o <= miss_is_instr_i;
      // a fetch is never a store
      ctx_is_store_o <= miss_is_store_i & ~miss_is_instr_i;
      ctx_mxr_o      <= mxr_i;
      ctx_root_ppn_o <= satp_ppn_i;
    end
  end

endmodule

// ==== ptw_pkg.sv ====
// ------------------------------
// shared types for the Sv32 page-table walker
// widths come from ptw_defines.svh
// ------------------------------
`include "ptw_defines.svh"

package ptw_pkg;

  // ------------------------------
  // address and page types
  // ------------------------------

  // virtual address as seen by the TLB
  typedef logic [`PTW_VLEN-1:0] vaddr_t;

  // physical address, 34 bits in Sv32
  typedef logic [`PTW_PLEN-1:0] paddr_t;

  // physical page number
  typedef logic [`PTW_PPNW-1:0] ppn_t;

  // both vpn fields together
  typedef logic [2*`PTW_VPNW-1:0] vpn_t;

  // address-space identifier
  typedef logic [`PTW_ASIDW-1:0] asid_t;

  // raw page-table entry as read from memory
  typedef logic [31:0] pte_t;

  // ------------------------------
  // walk sequencing
  // ------------------------------
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_PTE,
    DONE
  } walk_state_e;

endpackage

// ==== ptw_pte_check.sv ====
// ------------------------------
// Sv32 PTE classifier, purely combinational
// level_i is 1 for the root table and 0 for the leaf table
// ------------------------------
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_pte_check
  import ptw_pkg::*;
(
  input  pte_t pte_i,
  input  logic level_i,
  input  logic is_instr_i,
  input  logic is_store_i,
  input  logic mxr_i,
  output logic is_fault_o,
  output logic is_leaf_o,
  output logic is_pointer_o
);

  logic v, r, w, x, a, d;
  logic invalid;
  logic leaf;
  logic ptr_at_last;
  logic misaligned;
  logic perm_fault;

  // unpack the bits we care about
  assign v = pte_i[`PTW_PTE_V];
  assign r = pte_i[`PTW_PTE_R];
  assign w = pte_i[`PTW_PTE_W];
  assign x = pte_i[`PTW_PTE_X];
  assign a = pte_i[`PTW_PTE_A];
  assign d = pte_i[`PTW_PTE_D];

  // not valid, or the reserved write-only encoding
  assign invalid = ~v | (~r & w);

  // r or x marks a leaf, otherwise a pointer
  assign leaf = r | x;

  // no table below level 0
  assign ptr_at_last = ~leaf & ~level_i;

  // superpage needs ppn[0] clear, i.e. the low ten ppn bits
  assign misaligned = level_i & (pte_i[`PTW_PTE_PPN_LSB +: `PTW_VPNW] != '0);

  // access permissions
  // a is managed by software, so a missing a always faults
  always_comb begin
    if (is_instr_i) begin
      perm_fault = ~x | ~a;
    end else if (is_store_i) begin
      perm_fault = ~w | ~d | ~a;
    end else begin
      // loads may read x-only pages when mxr is set
      perm_fault = ~a | ~(r | (x & mxr_i));
    end
  end

  // ------------------------------
  // final classification
  // ------------------------------
  assign is_fault_o   = invalid | ptr_at_last | (leaf & (misaligned | perm_fault));
  assign is_leaf_o    = ~is_fault_o & leaf;
  assign is_pointer_o = ~is_fault_o & ~leaf;

endmodule

// ==== ptw_tb.sv ====
// ------------------------------
// testbench for the Sv32 walker with ptw_top as UUT
// memory model grants and answers after 0 to 3 random cycles
// a PTE read from an address the row did not map ends the run
// ------------------------------
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_tb
  import ptw_pkg::*;
();

  localparam int PERIOD     = 20;
  localparam int ROW_CYCLES = 200;
  localparam int PASSES     = 2;

  // access kinds
  localparam logic [1:0] LOAD  = 2'd0;
  localparam logic [1:0] STORE = 2'd1;
  localparam logic [1:0] FETCH = 2'd2;

  // pte flag masks
  localparam logic [7:0] PV = 8'h01 << `PTW_PTE_V;
  localparam logic [7:0] PR = 8'h01 << `PTW_PTE_R;
  localparam logic [7:0] PW = 8'h01 << `PTW_PTE_W;
  localparam logic [7:0] PX = 8'h01 << `PTW_PTE_X;
  localparam logic [7:0] PU = 8'h01 << `PTW_PTE_U;
  localparam logic [7:0] PG = 8'h01 << `PTW_PTE_G;
  localparam logic [7:0] PA = 8'h01 << `PTW_PTE_A;
  localparam logic [7:0] PD = 8'h01 << `PTW_PTE_D;

  logic   clk;
  logic   rst_n;
  logic   miss_valid;
  vaddr_t miss_vaddr;
  asid_t  miss_asid;
  logic   miss_is_instr;
  logic   miss_is_store;
  logic   mxr;
  ppn_t   satp_ppn;
  logic   miss_ready;
  logic   mem_req;
  paddr_t mem_addr;
  logic   mem_gnt;
  logic   mem_rvalid;
  pte_t   mem_rdata;
  logic   upd_valid;
  vpn_t   upd_vpn;
  ppn_t   upd_ppn;
  asid_t  upd_asid;
  logic   upd_superpage;
  logic   upd_global;
  logic   upd_u;
  logic   upd_r;
  logic   upd_w;
  logic   upd_x;
  logic   fault;
  vaddr_t fault_vaddr;

  // page-table memory, keyed by physical address
  pte_t mem [paddr_t];
  logic table_ready = 1'b0;

  // ------------------------------
  // stimulus table, one element per row in each queue
  // ------------------------------
  vaddr_t     row_va[$];
  asid_t      row_asid[$];
  logic [1:0] row_kind[$];
  logic       row_mxr[$];
  pte_t       row_l1[$];
  pte_t       row_l0[$];
  logic       row_fault[$];
  ppn_t       row_ppn[$];
  logic       row_super[$];
  logic       row_glob[$];
  // expected u, r, w, x from msb down
  logic [3:0] row_urwx[$];

  ptw_top UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .miss_valid_i    (miss_valid),
    .miss_vaddr_i    (miss_vaddr),
    .miss_asid_i     (miss_asid),
    .miss_is_instr_i (miss_is_instr),
    .miss_is_store_i (miss_is_store),
    .mxr_i           (mxr),
    .satp_ppn_i      (satp_ppn),
    .miss_ready_o    (miss_ready),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_gnt_i       (mem_gnt),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata),
    .upd_valid_o     (upd_valid),
    .upd_vpn_o       (upd_vpn),
    .upd_ppn_o       (upd_ppn),
    .upd_asid_o      (upd_asid),
    .upd_superpage_o (upd_superpage),
    .upd_global_o    (upd_global),
    .upd_u_o         (upd_u),
    .upd_r_o         (upd_r),
    .upd_w_o         (upd_w),
    .upd_x_o         (upd_x),
    .fault_o         (fault),
    .fault_vaddr_o   (fault_vaddr)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic end_in_failure(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // next rising edge plus the drive and sample offset
  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      end_in_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  task automatic add_row(input vaddr_t va, input asid_t asid, input logic [1:0] kind,
                         input logic mx, input pte_t l1, input pte_t l0, input logic flt,
                         input ppn_t ppn, input logic sp, input logic gl,
                         input logic [3:0] urwx);
    row_va.push_back(va);
    row_asid.push_back(asid);
    row_kind.push_back(kind);
    row_mxr.push_back(mx);
    row_l1.push_back(l1);
    row_l0.push_back(l0);
    row_fault.push_back(flt);
    row_ppn.push_back(ppn);
    row_super.push_back(sp);
    row_glob.push_back(gl);
    row_urwx.push_back(urwx);
  endtask

  // va, asid, kind, mxr, level-1 pte, level-0 pte, then fault, ppn, superpage, global, urwx
  task automatic build_table();
    // two-level load
    add_row(32'h4030_5123, 9'h011, LOAD, 1'b0, make_pte(22'h00234, PV),
            make_pte(22'h0abcd, PV|PR|PU|PA), 1'b0, 22'h0abcd, 1'b0, 1'b0, 4'b1100);
    // superpage, aligned then misaligned
    add_row(32'h8047_8abc, 9'h1a5, LOAD, 1'b0, make_pte(22'h12c00, PV|PR|PW|PA|PD),
            32'h0, 1'b0, 22'h12c00, 1'b1, 1'b0, 4'b0110);
    add_row(32'h8047_8abc, 9'h1a5, LOAD, 1'b0, make_pte(22'h12c01, PV|PR|PW|PA|PD),
            32'h0, 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    // invalid entries and a pointer at level 0
    add_row(32'h0123_4567, 9'h002, LOAD, 1'b0, make_pte(22'h00234, PR|PA),
            32'h0, 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    add_row(32'h0567_8000, 9'h003, STORE, 1'b0, make_pte(22'h00234, PV|PW|PA|PD),
            32'h0, 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    add_row(32'hc00f_f000, 9'h004, LOAD, 1'b0, make_pte(22'h00300, PV),
            make_pte(22'h00555, PV), 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    // fetch permission
    add_row(32'h1000_2000, 9'h005, FETCH, 1'b0, make_pte(22'h00300, PV),
            make_pte(22'h00777, PV|PR|PA), 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    add_row(32'h1000_3000, 9'h005, FETCH, 1'b0, make_pte(22'h00300, PV),
            make_pte(22'h00778, PV|PX|PU|PA), 1'b0, 22'h00778, 1'b0, 1'b0, 4'b1001);
    // x-only page, mxr low then high
    add_row(32'h2040_1004, 9'h006, LOAD, 1'b0, make_pte(22'h00400, PV),
            make_pte(22'h3ffff, PV|PX|PA), 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    add_row(32'h2040_1004, 9'h006, LOAD, 1'b1, make_pte(22'h00400, PV),
            make_pte(22'h3ffff, PV|PX|PA), 1'b0, 22'h3ffff, 1'b0, 1'b0, 4'b0001);
    // store needs d
    add_row(32'h3ff0_0ff8, 9'h007, STORE, 1'b0, make_pte(22'h00500, PV),
            make_pte(22'h01234, PV|PR|PW|PA), 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    add_row(32'h3ff0_0ff8, 9'h007, STORE, 1'b0, make_pte(22'h00500, PV),
            make_pte(22'h01234, PV|PR|PW|PA|PD), 1'b0, 22'h01234, 1'b0, 1'b0, 4'b0110);
    // leaf without a
    add_row(32'h5555_5000, 9'h008, LOAD, 1'b0, make_pte(22'h00600, PV),
            make_pte(22'h02222, PV|PR), 1'b1, 22'h0, 1'b0, 1'b0, 4'b0000);
    // global from either level
    add_row(32'h6000_1000, 9'h1ff, LOAD, 1'b0, make_pte(22'h00700, PV|PG),
            make_pte(22'h03333, PV|PR|PA), 1'b0, 22'h03333, 1'b0, 1'b1, 4'b0100);
    add_row(32'h6000_2000, 9'h100, LOAD, 1'b0, make_pte(22'h00700, PV),
            make_pte(22'h03334, PV|PR|PA|PG), 1'b0, 22'h03334, 1'b0, 1'b1, 4'b0100);
    add_row(32'hfe00_0000, 9'h0aa, FETCH, 1'b0, make_pte(22'h3fc00, PV|PR|PX|PA|PG),
            32'h0, 1'b0, 22'h3fc00, 1'b1, 1'b1, 4'b0101);
  endtask

  // ------------------------------
  // one row: map the ptes, send the miss, check the end pulse
  // ------------------------------
  task automatic apply_row(input int i);
    vaddr_t va;
    ppn_t   root;
    pte_t   l1;
    int     waited;
    va   = row_va[i];
    l1   = row_l1[i];
    root = 22'h00100 + 22'(i);
    // root entry, and the level-0 entry its ppn would name
    mem.delete();
    mem[{root, va[31:22], 2'b00}] = l1;
    mem[{l1[31:10], va[21:12], 2'b00}] = row_l0[i];
    miss_vaddr    = va;
    miss_asid     = row_asid[i];
    miss_is_instr = (row_kind[i] == FETCH);
    miss_is_store = (row_kind[i] == STORE);
    mxr           = row_mxr[i];
    satp_ppn      = root;
    miss_valid    = 1'b1;
    waited = 0;
    while (!miss_ready) begin
      wait_cycle();
      waited++;
      if (waited > ROW_CYCLES) begin
        end_in_failure("the walker never accepted the miss");
      end
    end
    // accepted on this edge, so scramble the inputs
    wait_cycle();
    miss_valid    = 1'b0;
    miss_vaddr    = ~va;
    miss_asid     = ~row_asid[i];
    miss_is_instr = ~miss_is_instr;
    miss_is_store = ~miss_is_store;
    mxr           = ~row_mxr[i];
    satp_ppn      = ~root;
    waited = 0;
    while (!(upd_valid || fault)) begin
      wait_cycle();
      waited++;
      if (waited > ROW_CYCLES) begin
        end_in_failure("no update or fault pulse after the miss was accepted");
      end
    end
    check_field("fault_o", 64'(fault), 64'(row_fault[i]));
    check_field("upd_valid_o", 64'(upd_valid), 64'(!row_fault[i]));
    check_field("miss_ready_o", 64'(miss_ready), 64'd0);
    if (row_fault[i]) begin
      check_field("fault_vaddr_o", 64'(fault_vaddr), 64'(va));
    end else begin
      check_field("upd_vpn_o", 64'(upd_vpn), 64'(va[31:12]));
      check_field("upd_ppn_o", 64'(upd_ppn), 64'(row_ppn[i]));
      check_field("upd_asid_o", 64'(upd_asid), 64'(row_asid[i]));
      check_field("upd_superpage_o", 64'(upd_superpage), 64'(row_super[i]));
      check_field("upd_global_o", 64'(upd_global), 64'(row_glob[i]));
      check_field("upd_u_o", 64'(upd_u), 64'(row_urwx[i][3]));
      check_field("upd_r_o", 64'(upd_r), 64'(row_urwx[i][2]));
      check_field("upd_w_o", 64'(upd_w), 64'(row_urwx[i][1]));
      check_field("upd_x_o", 64'(upd_x), 64'(row_urwx[i][0]));
    end
    // the pulse lasts one cycle and ready returns right after
    wait_cycle();
    check_field("upd_valid_o", 64'(upd_valid), 64'd0);
    check_field("fault_o", 64'(fault), 64'd0);
    check_field("miss_ready_o", 64'(miss_ready), 64'd1);
  endtask

  // ------------------------------
  // memory model, one request at a time
  // ------------------------------
  initial begin
    paddr_t      addr;
    int unsigned gnt_dly;
    int unsigned rv_dly;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    void'($urandom(77));
    forever begin
      wait_cycle();
      if (rst_n && mem_req) begin
        addr    = mem_addr;
        gnt_dly = $urandom_range(3, 0);
        rv_dly  = $urandom_range(3, 0);
        repeat (gnt_dly) wait_cycle();
        mem_gnt = 1'b1;
        wait_cycle();
        mem_gnt = 1'b0;
        repeat (rv_dly) wait_cycle();
        if (!mem.exists(addr)) begin
          end_in_failure($sformatf("PTE read from unmapped address 0x%0h", addr));
        end
        mem_rvalid = 1'b1;
        mem_rdata  = mem[addr];
        wait_cycle();
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
      end
    end
  end

  // watchdog sized from the number of rows applied
  initial begin
    int limit;
    wait (table_ready);
    limit = 20 + PASSES * row_va.size() * ROW_CYCLES;
    repeat (limit) @(posedge clk);
    end_in_failure("watchdog expired before all rows finished");
  end

  // stop at the first failed protocol assertion
  initial begin
    wait (UUT.u_assert.fail_count != 0);
    end_in_failure("a protocol assertion failed during the run");
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst_n         = 1'b0;
    miss_valid    = 1'b0;
    miss_vaddr    = '0;
    miss_asid     = '0;
    miss_is_instr = 1'b0;
    miss_is_store = 1'b0;
    mxr           = 1'b0;
    satp_ppn      = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    // outputs while still in reset
    check_field("miss_ready_o", 64'(miss_ready), 64'd1);
    check_field("mem_req_o", 64'(mem_req), 64'd0);
    check_field("upd_valid_o", 64'(upd_valid), 64'd0);
    check_field("fault_o", 64'(fault), 64'd0);
    rst_n = 1'b1;
    wait_cycle();
    // table twice, so each row meets other random delays
    for (int p = 0; p < PASSES; p++) begin
      for (int i = 0; i < row_va.size(); i++) begin
        apply_row(i);
      end
    end
    if (UUT.u_assert.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      end_in_failure("a protocol assertion failed during the run");
    end
  end

endmodule

// ==== ptw_tb_assertions.sv ====
// ------------------------------
// protocol assertions, bound into ptw_top
// fail_count is read by the testbench at the end of the run
// ------------------------------
`timescale 1ns/1ps

module ptw_tb_assertions
  import ptw_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  input logic   miss_valid_i,
  input logic   miss_ready_o,
  input logic   mem_req_o,
  input paddr_t mem_addr_o,
  input logic   mem_gnt_i,
  input logic   upd_valid_o,
  input logic   fault_o
);

  int unsigned fail_count = 0;
  logic        walk_open;

  // from the accept edge until the end pulse is over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      walk_open <= 1'b0;
    end else if (miss_valid_i && miss_ready_o) begin
      walk_open <= 1'b1;
    end else if (upd_valid_o || fault_o) begin
      walk_open <= 1'b0;
    end
  end

  // request and address held until granted
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("memory request dropped or changed before its grant");
      fail_count++;
    end

  // exactly one kind of end pulse
  one_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(upd_valid_o && fault_o))
    else begin
      $error("update and fault pulses high together");
      fail_count++;
    end

  // no second miss while a walk is open
  no_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    walk_open |-> !miss_ready_o)
    else begin
      $error("miss_ready high during a walk");
      fail_count++;
    end

endmodule

bind ptw_top ptw_tb_assertions u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .miss_valid_i (miss_valid_i),
  .miss_ready_o (miss_ready_o),
  .mem_req_o    (mem_req_o),
  .mem_addr_o   (mem_addr_o),
  .mem_gnt_i    (mem_gnt_i),
  .upd_valid_o  (upd_valid_o),
  .fault_o      (fault_o)
);

// ==== ptw_tlb_update.sv ====
// ------------------------------
// end-of-walk formatter
// exactly one of upd_valid_o or fault_o pulses, one cycle after finish
// ------------------------------
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_tlb_update
  import ptw_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   finish_i,
  input  logic   finish_fault_i,
  input  pte_t   pte_i,
  input  logic   level_i,
  input  logic   global_i,
  input  vaddr_t ctx_vaddr_i,
  input  asid_t  ctx_asid_i,
  output logic   upd_valid_o,
  output vpn_t   upd_vpn_o,
  output ppn_t   upd_ppn_o,
  output asid_t  upd_asid_o,
  output logic   upd_superpage_o,
  output logic   upd_global_o,
  output logic   upd_u_o,
  output logic   upd_r_o,
  output logic   upd_w_o,
  output logic   upd_x_o,
  output logic   fault_o,
  output vaddr_t fault_vaddr_o
);

  // strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      upd_valid_o <= 1'b0;
      fault_o     <= 1'b0;
    end else begin
      upd_valid_o <= finish_i & ~finish_fault_i;
      fault_o     <= finish_i & finish_fault_i;
    end
  end

  // entry and fault address, loaded on finish
  // a leaf found at level 1 is a 4 MiB superpage
  always_ff @(posedge clk_i) begin
    if (finish_i) begin
      upd_vpn_o       <= ctx_vaddr_i[`PTW_VLEN-1:`PTW_OFFW];
      upd_ppn_o       <= pte_i[`PTW_PTE_PPN_LSB +: `PTW_PPNW];
      upd_asid_o      <= ctx_asid_i;
      upd_superpage_o <= level_i;
      upd_global_o    <= global_i;
      upd_u_o         <= pte_i[`PTW_PTE_U];
      upd_r_o         <= pte_i[`PTW_PTE_R];
      upd_w_o         <= pte_i[`PTW_PTE_W];
      upd_x_o         <= pte_i[`PTW_PTE_X];
      fault_vaddr_o   <= ctx_vaddr_i;
    end
  end

endmodule

// ==== ptw_top.sv ====
// ------------------------------
// Sv32 page-table walker top level
// no flush, a started walk always completes
// ------------------------------
`timescale 1ns/1ps

module ptw_top
  import ptw_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // miss side
  input  logic   miss_valid_i,
  input  vaddr_t miss_vaddr_i,
  input  asid_t  miss_asid_i,
  input  logic   miss_is_instr_i,
  input  logic   miss_is_store_i,
  input  logic   mxr_i,
  input  ppn_t   satp_ppn_i,
  output logic   miss_ready_o,
  // memory side
  output logic   mem_req_o,
  output paddr_t mem_addr_o,
  input  logic   mem_gnt_i,
  input  logic   mem_rvalid_i,
  input  pte_t   mem_rdata_i,
  // tlb update side
  output logic   upd_valid_o,
  output vpn_t   upd_vpn_o,
  output ppn_t   upd_ppn_o,
  output asid_t  upd_asid_o,
  output logic   upd_superpage_o,
  output logic   upd_global_o,
  output logic   upd_u_o,
  output logic   upd_r_o,
  output logic   upd_w_o,
  output logic   upd_x_o,
  output logic   fault_o,
  output vaddr_t fault_vaddr_o
);

  // captured context
  logic   accept, busy;
  vaddr_t ctx_vaddr;
  asid_t  ctx_asid;
  logic   ctx_is_instr, ctx_is_store, ctx_mxr;
  ppn_t   ctx_root_ppn;
  // walk control
  logic   fetch, level, finish, finish_fault, global_flag;
  paddr_t fetch_addr;
  // returned entry and its class
  logic   pte_valid;
  pte_t   pte;
  logic   is_fault, is_leaf, is_pointer;

  ptw_miss_capture u_capture (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss_valid_i    (miss_valid_i),
    .miss_vaddr_i    (miss_vaddr_i),
    .miss_asid_i     (miss_asid_i),
    .miss_is_instr_i (miss_is_instr_i),
    .miss_is_store_i (miss_is_store_i),
    .mxr_i           (mxr_i),
    .satp_ppn_i      (satp_ppn_i),
    .busy_i          (busy),
    .miss_ready_o    (miss_ready_o),
    .accept_o        (accept),
    .ctx_vaddr_o     (ctx_vaddr),
    .ctx_asid_o      (ctx_asid),
    .ctx_is_instr_o  (ctx_is_instr),
    .ctx_is_store_o  (ctx_is_store),
    .ctx_mxr_o       (ctx_mxr),
    .ctx_root_ppn_o  (ctx_root_ppn)
  );

  ptw_walk_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .accept_i       (accept),
    .ctx_vaddr_i    (ctx_vaddr),
    .ctx_root_ppn_i (ctx_root_ppn),
    .pte_valid_i    (pte_valid),
    .pte_i          (pte),
    .is_fault_i     (is_fault),
    .is_leaf_i      (is_leaf),
    .is_pointer_i   (is_pointer),
    .busy_o         (busy),
    .fetch_o        (fetch),
    .fetch_addr_o   (fetch_addr),
    .level_o        (level),
    .finish_o       (finish),
    .finish_fault_o (finish_fault),
    .global_o       (global_flag)
  );

  ptw_mem_port u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_i      (fetch),
    .fetch_addr_i (fetch_addr),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .pte_valid_o  (pte_valid),
    .pte_o        (pte)
  );

  ptw_pte_check u_check (
    .pte_i        (pte),
    .level_i      (level),
    .is_instr_i   (ctx_is_instr),
    .is_store_i   (ctx_is_store),
    .mxr_i        (ctx_mxr),
    .is_fault_o   (is_fault),
    .is_leaf_o    (is_leaf),
    .is_pointer_o (is_pointer)
  );

  ptw_tlb_update u_update (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .finish_i        (finish),
    .finish_fault_i  (finish_fault),
    .pte_i           (pte),
    .level_i         (level),
    .global_i        (global_flag),
    .ctx_vaddr_i     (ctx_vaddr),
    .ctx_asid_i      (ctx_asid),
    .upd_valid_o     (upd_valid_o),
    .upd_vpn_o       (upd_vpn_o),
    .upd_ppn_o       (upd_ppn_o),
    .upd_asid_o      (upd_asid_o),
    .upd_superpage_o (upd_superpage_o),
    .upd_global_o    (upd_global_o),
    .upd_u_o         (upd_u_o),
    .upd_r_o         (upd_r_o),
    .upd_w_o         (upd_w_o),
    .upd_x_o         (upd_x_o),
    .fault_o         (fault_o),
    .fault_vaddr_o   (fault_vaddr_o)
  );

endmodule

// ==== ptw_walk_fsm.sv ====
// ------------------------------
// walk sequencer for the two Sv32 levels
// decides in the pte_valid cycle, then holds busy through the end pulse
// ------------------------------
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_walk_fsm
  import ptw_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   accept_i,
  input  vaddr_t ctx_vaddr_i,
  input  ppn_t   ctx_root_ppn_i,
  input  logic   pte_valid_i,
  input  pte_t   pte_i,
  input  logic   is_fault_i,
  input  logic   is_leaf_i,
  input  logic   is_pointer_i,
  output logic   busy_o,
  output logic   fetch_o,
  output paddr_t fetch_addr_o,
  output logic   level_o,
  output logic   finish_o,
  output logic   finish_fault_o,
  output logic   global_o
);

  walk_state_e state_q, state_d;
  logic        level_q;
  logic        global_q;
  logic [`PTW_VPNW-1:0] vpn1;
  logic [`PTW_VPNW-1:0] vpn0;

  // vpn fields of the captured address
  assign vpn1 = ctx_vaddr_i[`PTW_VLEN-1 -: `PTW_VPNW];
  assign vpn0 = ctx_vaddr_i[`PTW_OFFW +: `PTW_VPNW];

  assign busy_o  = (state_q != IDLE);
  assign level_o = level_q;

  // G seen on any entry read so far, including the one arriving now
  assign global_o = global_q | (pte_valid_i & pte_i[`PTW_PTE_G]);

  // pte address, 4-byte entries
  // root table first, then the table the pointer names
  assign fetch_addr_o = (state_q == REQ) ? {ctx_root_ppn_i, vpn1, 2'b00}
                                         : {pte_i[`PTW_PTE_PPN_LSB +: `PTW_PPNW], vpn0, 2'b00};

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_d        = state_q;
    fetch_o        = 1'b0;
    finish_o       = 1'b0;
    finish_fault_o = 1'b0;
    case (state_q)
      IDLE: begin
        // context is registered on accept, usable next cycle
        if (accept_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        fetch_o = 1'b1;
        state_d = WAIT_PTE;
      end
      WAIT_PTE: begin
        if (pte_valid_i) begin
          if (is_pointer_i) begin
            // descend and fetch the level-0 entry right away
            fetch_o = 1'b1;
          end else begin
            finish_o       = 1'b1;
            finish_fault_o = is_fault_i & ~is_leaf_i;
            state_d        = DONE;
          end
        end
      end
      // end pulse goes out here
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      level_q  <= 1'b1;
      global_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept_i) begin
        level_q  <= 1'b1;
        global_q <= 1'b0;
      end else if (state_q == WAIT_PTE && pte_valid_i) begin
        global_q <= global_o;
        if (is_pointer_i) begin
          level_q <= 1'b0;
        end
      end
    end
  end

endmodule
